// File: sim.f
+incdir+sim
hw/mdu_pkg.sv
hw/div_operand_prep.sv
hw/div_iter.sv
hw/mul_iter.sv
hw/result_arbiter.sv
hw/mdu_top.sv
sim/tb_clk_gen.sv
sim/mdu_tb.sv

// File: Bender.yml
package:
  name: mdu

sources:
  - hw/mdu_pkg.sv
  - hw/div_operand_prep.sv
  - hw/div_iter.sv
  - hw/mul_iter.sv
  - hw/result_arbiter.sv
  - hw/mdu_top.sv
  - target: test
    include_dirs:
      - sim
    files:
      - sim/tb_clk_gen.sv
      - sim/mdu_tb.sv

// File: sim/mdu_ref_model.svh
`ifndef MDU_REF_MODEL_SVH
`define MDU_REF_MODEL_SVH

function automatic logic [63:0] word_to_xlen(input logic [31:0] v);
  return {{32{v[31]}}, v};
endfunction

// RV64M results straight from the ISA rules, using wide arithmetic
function automatic logic [63:0] ref_result(input mdu_op_e op, input logic [63:0] a,
                                           input logic [63:0] b);
  logic [127:0]       prod_uu;
  logic [127:0]       prod_ss;
  logic [127:0]       prod_su;
  logic signed [63:0] sa;
  logic signed [63:0] sb;
  logic signed [31:0] wa;
  logic signed [31:0] wb;
  logic               ovf64;
  logic               ovf32;
  logic [63:0]        res;
  sa      = a;
  sb      = b;
  wa      = a[31:0];
  wb      = b[31:0];
  prod_uu = {64'b0, a} * {64'b0, b};
  prod_ss = {{64{a[63]}}, a} * {{64{b[63]}}, b};       // low 128 bits of signed product
  prod_su = {{64{a[63]}}, a} * {64'b0, b};
  ovf64   = (a == 64'h8000_0000_0000_0000) && (b == '1);
  ovf32   = (a[31:0] == 32'h8000_0000) && (b[31:0] == 32'hffff_ffff);
  res     = '0;
  case (op)
    OP_MUL:    res = prod_uu[63:0];
    OP_MULH:   res = prod_ss[127:64];
    OP_MULHSU: res = prod_su[127:64];
    OP_MULHU:  res = prod_uu[127:64];
    OP_MULW:   res = word_to_xlen(prod_uu[31:0]);
    OP_DIV: begin
      if (b == 0) res = '1;
      else if (ovf64) res = a;
      else res = sa / sb;
    end
    OP_DIVU:   res = (b == 0) ? '1 : a / b;
    OP_REM: begin
      if (b == 0) res = a;
      else if (ovf64) res = '0;
      else res = sa % sb;                               // sign follows dividend
    end
    OP_REMU:   res = (b == 0) ? a : a % b;
    OP_DIVW: begin
      if (wb == 0) res = '1;
      else if (ovf32) res = word_to_xlen(a[31:0]);
      else res = word_to_xlen(wa / wb);
    end
    OP_DIVUW:  res = (b[31:0] == 0) ? '1 : word_to_xlen(a[31:0] / b[31:0]);
    OP_REMW: begin
      if (wb == 0) res = word_to_xlen(a[31:0]);
      else if (ovf32) res = '0;
      else res = word_to_xlen(wa % wb);
    end
    OP_REMUW:  res = word_to_xlen((b[31:0] == 0) ? a[31:0] : a[31:0] % b[31:0]);
    default:   res = '0;
  endcase
  return res;
endfunction

`endif

// File: sim/mdu_tb.sv
`default_nettype none

module mdu_tb;
  import mdu_pkg::*;

  localparam int N_MUL     = 40;
  localparam int N_DIV     = 60;
  localparam int N_SPEC    = 16;
  localparam int N_CONC    = 60;
  localparam int N_BP      = 60;
  localparam int TOTAL_OPS = N_MUL + N_DIV + N_SPEC + N_CONC + N_BP;
  localparam int MODE_MUL  = 0;
  localparam int MODE_DIV  = 1;
  localparam int MODE_SPEC = 2;
  localparam int MODE_MIX  = 3;

  logic             clk;
  logic             rst_n;
  logic             req_valid;
  mdu_req_t         req;
  logic             rsp_ready;
  logic             mul_busy;
  logic             div_busy;
  logic             rsp_valid;
  mdu_rsp_t         rsp;

  integer           seed = 32'he523;
  logic [XLEN-1:0]  exp_val [2**TAG_W];   // scoreboard, indexed by tag
  mdu_op_e          exp_op  [2**TAG_W];
  bit               pending [2**TAG_W];
  int               outstanding;
  int               errors;
  int               checks;
  int               responses;
  logic [TAG_W-1:0] next_tag;
  bit               bp_on;
  bit               stall_q;
  mdu_rsp_t         stall_rsp;

  `include "mdu_ref_model.svh"

  tb_clk_gen u_clk (.clk_o(clk));

  mdu_top dut0 (
    .clk         (clk),
    .rst_n       (rst_n),
    .req_valid_i (req_valid),
    .req_i       (req),
    .rsp_ready_i (rsp_ready),
    .mul_busy_o  (mul_busy),
    .div_busy_o  (div_busy),
    .rsp_valid_o (rsp_valid),
    .rsp_o       (rsp)
  );

  // ==========================================================
  // stimulus helpers
  // ==========================================================
  task automatic next_cycle();
    @(posedge clk);
    #1;
    req_valid = 1'b0;
    rsp_ready = bp_on ? (($random(seed) & 1) == 1) : 1'b1;   // random stall when enabled
  endtask

  function automatic logic [XLEN-1:0] rand_operand();
    logic [31:0] hi;
    logic [31:0] lo;
    int          pick;
    hi   = $random(seed);
    lo   = $random(seed);
    pick = $random(seed) & 15;
    case (pick)                                           // a quarter go to corner values
      0:       return '0;
      1:       return '1;
      2:       return 64'h8000_0000_0000_0000;
      3:       return {hi, 32'h8000_0000};
      default: return {hi, lo};
    endcase
  endfunction

  function automatic mdu_req_t make_request(input int mode, input bit to_div);
    mdu_req_t    r;
    int          k;
    logic [31:0] hi;
    bit          word;
    k     = $random(seed) & 255;
    hi    = $random(seed);
    r.tag = next_tag;
    r.op  = to_div ? mdu_op_e'(OP_DIV + k % 8) : mdu_op_e'(k % 5);
    r.a   = rand_operand();
    r.b   = rand_operand();
    if (mode == MODE_SPEC) begin
      word = (r.op >= OP_DIVW);
      if (k[7]) begin
        r.b = word ? {hi, 32'h0} : '0;                      // zero divisor, junk upper half
      end else begin
        r.a = word ? {hi, 32'h8000_0000} : 64'h8000_0000_0000_0000;
        r.b = word ? {~hi, 32'hffff_ffff} : '1;
      end
    end
    return r;
  endfunction

  task automatic send(input mdu_req_t r);
    req             = r;
    req_valid       = 1'b1;
    exp_val[r.tag]  = ref_result(r.op, r.a, r.b);
    exp_op[r.tag]   = r.op;
    pending[r.tag]  = 1'b1;
    outstanding++;
    next_tag        = next_tag + 1'b1;
  endtask

  task automatic run_ops(input string name, input int n, input int mode, input bit serial);
    int issued;
    int errs_before;
    int resp_before;
    bit want_div;
    issued      = 0;
    errs_before = errors;
    resp_before = responses;
    while (issued < n) begin
      next_cycle();
      if (serial && outstanding != 0) continue;
      if (pending[next_tag]) continue;
      case (mode)
        MODE_MUL: want_div = 1'b0;
        MODE_MIX: want_div = mul_busy ? 1'b1 : (div_busy ? 1'b0 : ($random(seed) & 1));
        default:  want_div = 1'b1;
      endcase
      if (want_div ? div_busy : mul_busy) continue;       // unit would drop the strobe
      send(make_request(mode, want_div));
      issued++;
    end
    while (outstanding != 0) next_cycle();
    $display("test %s: %0d ops, %0d responses, %s", name, n, responses - resp_before,
             (errors == errs_before) ? "passed" : "failed");
  endtask

  // ==========================================================
  // response monitor, sampled mid-cycle
  // ==========================================================
  task automatic check_rsp(input mdu_rsp_t r);
    checks++;
    responses++;
    assert (pending[r.tag]) else begin
      errors++;
      $display("tag %0d came back with no request outstanding, result duplicated", r.tag);
    end
    if (pending[r.tag]) begin
      assert (r.value === exp_val[r.tag]) else begin
        errors++;
        $display("error at %0t: tag %0d %s returned %h, expected %h", $time, r.tag,
                 exp_op[r.tag].name(), r.value, exp_val[r.tag]);
      end
      pending[r.tag] = 1'b0;
      outstanding--;
    end
  endtask

  always @(negedge clk) begin
    if (!rst_n) begin                                     // reset is active high
      if (stall_q) begin
        checks++;
        assert (rsp_valid && rsp === stall_rsp) else begin
          errors++;
          $display("error at %0t: response changed or dropped while stalled", $time);
        end
      end
      if (rsp_valid && rsp_ready) check_rsp(rsp);
      stall_q   = rsp_valid && !rsp_ready;
      stall_rsp = rsp;
    end
  end

  initial begin : watchdog
    repeat (TOTAL_OPS * 200) @(posedge clk);
    $display("timeout: results still missing after %0d cycles", TOTAL_OPS * 200);
    $display("TEST FAIL");
    $finish;
  end

  // ==========================================================
  // test sequence
  // ==========================================================
  initial begin
    rst_n       = 1'b1;
    req_valid   = 1'b0;
    req         = '0;
    rsp_ready   = 1'b1;
    bp_on       = 1'b0;
    stall_q     = 1'b0;
    stall_rsp   = '0;
    outstanding = 0;
    errors      = 0;
    checks      = 0;
    responses   = 0;
    next_tag    = '0;
    for (int i = 0; i < 2**TAG_W; i++) pending[i] = 1'b0;
    repeat (4) next_cycle();
    rst_n = 1'b0;
    next_cycle();
    checks++;
    assert (!rsp_valid && !mul_busy && !div_busy) else begin
      errors++;
      $display("error at %0t: valid or busy high after reset", $time);
    end
    $display("test reset: %s", (errors == 0) ? "passed" : "failed");

    run_ops("multiply", N_MUL, MODE_MUL, 1'b1);
    run_ops("divide", N_DIV, MODE_DIV, 1'b1);
    run_ops("special", N_SPEC, MODE_SPEC, 1'b1);
    run_ops("concurrency", N_CONC, MODE_MIX, 1'b0);
    bp_on = 1'b1;
    run_ops("back-pressure", N_BP, MODE_MIX, 1'b0);
    bp_on = 1'b0;

    $display("summary: %0d checks, %0d responses, %0d errors", checks, responses, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: sim/tb_clk_gen.sv
`default_nettype none

module tb_clk_gen (
  output logic clk_o
);

  initial begin
    clk_o = 1'b0;
  end

  always #4 clk_o = ~clk_o;   // period 8

endmodule

`default_nettype wire

// File: hw/mdu_top.sv
`default_nettype none

module mdu_top (
  input  wire                     clk,
  input  wire                     rst_n,
  input  wire                     req_valid_i,
  input  wire mdu_pkg::mdu_req_t  req_i,
  input  wire                     rsp_ready_i,
  output logic                    mul_busy_o,
  output logic                    div_busy_o,
  output logic                    rsp_valid_o,
  output mdu_pkg::mdu_rsp_t       rsp_o
);
  import mdu_pkg::*;

  logic     mul_done;
  logic     div_done;
  logic     mul_grant;
  logic     div_grant;
  mdu_rsp_t mul_rsp;
  mdu_rsp_t div_rsp;

  // ==========================================================
  // compute units, both see every request
  // ==========================================================
  mul_iter u_mul (
    .clk         (clk),
    .rst_n       (rst_n),
    .req_valid_i (req_valid_i),
    .req_i       (req_i),
    .grant_i     (mul_grant),
    .busy_o      (mul_busy_o),
    .done_o      (mul_done),
    .rsp_o       (mul_rsp)
  );

  div_iter u_div (
    .clk         (clk),
    .rst_n       (rst_n),
    .req_valid_i (req_valid_i),
    .req_i       (req_i),
    .grant_i     (div_grant),
    .busy_o      (div_busy_o),
    .done_o      (div_done),
    .rsp_o       (div_rsp)
  );

  result_arbiter u_arb (
    .clk         (clk),
    .rst_n       (rst_n),
    .mul_done_i  (mul_done),
    .mul_rsp_i   (mul_rsp),
    .div_done_i  (div_done),
    .div_rsp_i   (div_rsp),
    .rsp_ready_i (rsp_ready_i),
    .mul_grant_o (mul_grant),
    .div_grant_o (div_grant),
    .rsp_valid_o (rsp_valid_o),
    .rsp_o       (rsp_o)
  );

endmodule

`default_nettype wire

// File: hw/result_arbiter.sv
`default_nettype none

module result_arbiter (
  input  wire                     clk,
  input  wire                     rst_n,
  input  wire                     mul_done_i,
  input  wire mdu_pkg::mdu_rsp_t  mul_rsp_i,
  input  wire                     div_done_i,
  input  wire mdu_pkg::mdu_rsp_t  div_rsp_i,
  input  wire                     rsp_ready_i,
  output logic                    mul_grant_o,
  output logic                    div_grant_o,
  output logic                    rsp_valid_o,
  output mdu_pkg::mdu_rsp_t       rsp_o
);
  import mdu_pkg::*;

  logic last_div_q;    // divider was served last
  logic lock_q;        // stalled transfer pending
  logic lock_div_q;
  logic pick_fair;
  logic pick_div;
  logic xfer;

  assign pick_fair = div_done_i & (~mul_done_i | ~last_div_q);
  assign pick_div  = lock_q ? lock_div_q : pick_fair;      // keep rsp_o stable under stall

  assign rsp_valid_o = mul_done_i | div_done_i;
  assign rsp_o       = pick_div ? div_rsp_i : mul_rsp_i;
  assign xfer        = rsp_valid_o & rsp_ready_i;
  assign div_grant_o = xfer & pick_div;
  assign mul_grant_o = xfer & ~pick_div;

  always_ff @(posedge clk) begin
    if (rst_n) begin
      last_div_q <= 1'b0;
      lock_q     <= 1'b0;
      lock_div_q <= 1'b0;
    end else begin
      if (xfer) last_div_q <= pick_div;
      lock_q     <= rsp_valid_o & ~rsp_ready_i;
      lock_div_q <= pick_div;
    end
  end

endmodule

`default_nettype wire

// File: hw/mul_iter.sv
`default_nettype none

module mul_iter (
  input  wire                     clk,
  input  wire                     rst_n,
  input  wire                     req_valid_i,
  input  wire mdu_pkg::mdu_req_t  req_i,
  input  wire                     grant_i,
  output logic                    busy_o,
  output logic                    done_o,
  output mdu_pkg::mdu_rsp_t       rsp_o
);
  import mdu_pkg::*;

  mul_state_e          state_q;
  logic                accept;
  logic                is_word;
  logic                a_signed;
  logic                b_signed;
  logic                a_neg;
  logic                b_neg;
  logic [XLEN-1:0]     a_src;
  logic [XLEN-1:0]     b_src;
  logic [6:0]          cnt_q;
  logic [2*XLEN-1:0]   acc_q;
  logic [2*XLEN-1:0]   mcand_q;
  logic [XLEN-1:0]     mplier_q;
  logic                neg_q;
  mdu_op_e             op_q;
  logic [TAG_W-1:0]    tag_q;
  logic [2*XLEN-1:0]   prod;

  assign accept   = (state_q == MUL_IDLE) & req_valid_i & is_mul_op(req_i.op);
  assign is_word  = (req_i.op == OP_MULW);
  assign a_signed = req_i.op inside {OP_MULH, OP_MULHSU};
  assign b_signed = (req_i.op == OP_MULH);
  assign a_neg    = a_signed & req_i.a[XLEN-1];
  assign b_neg    = b_signed & req_i.b[XLEN-1];
  assign a_src    = is_word ? {32'b0, req_i.a[31:0]} : req_i.a;   // low half needs no sign
  assign b_src    = is_word ? {32'b0, req_i.b[31:0]} : req_i.b;

  always_ff @(posedge clk) begin
    if (rst_n) begin
      state_q <= MUL_IDLE;
      cnt_q   <= '0;
    end else begin
      case (state_q)
        MUL_IDLE: begin
          if (accept) begin
            state_q <= MUL_RUN;
            cnt_q   <= is_word ? 7'd32 : 7'd64;
          end
        end
        MUL_RUN: begin
          cnt_q <= cnt_q - 7'd1;
          if (cnt_q == 7'd1) state_q <= MUL_DONE;            // last partial product
        end
        MUL_DONE: begin
          if (grant_i) state_q <= MUL_IDLE;
        end
        default: state_q <= MUL_IDLE;
      endcase
    end
  end

  // shift-add datapath
  always_ff @(posedge clk) begin
    if (accept) begin
      acc_q    <= '0;
      mcand_q  <= {{XLEN{1'b0}}, a_neg ? -a_src : a_src};
      mplier_q <= b_neg ? -b_src : b_src;
      neg_q    <= a_neg ^ b_neg;
      op_q     <= req_i.op;
      tag_q    <= req_i.tag;
    end else if (state_q == MUL_RUN) begin
      if (mplier_q[0]) acc_q <= acc_q + mcand_q;
      mcand_q  <= {mcand_q[2*XLEN-2:0], 1'b0};
      mplier_q <= {1'b0, mplier_q[XLEN-1:1]};
    end
  end

  assign prod = neg_q ? -acc_q : acc_q;

  assign busy_o = (state_q != MUL_IDLE);
  assign done_o = (state_q == MUL_DONE);
  assign rsp_o  = '{value: (op_q == OP_MULW) ? sext32(prod[31:0]) :
                           (op_q == OP_MUL)  ? prod[XLEN-1:0] : prod[2*XLEN-1:XLEN],
                    tag:   tag_q};

endmodule

`default_nettype wire

// File: hw/div_iter.sv
`default_nettype none

module div_iter (
  input  wire                     clk,
  input  wire                     rst_n,
  input  wire                     req_valid_i,
  input  wire mdu_pkg::mdu_req_t  req_i,
  input  wire                     grant_i,
  output logic                    busy_o,
  output logic                    done_o,
  output mdu_pkg::mdu_rsp_t       rsp_o
);
  import mdu_pkg::*;

  div_state_e          state_q;
  div_prep_t           prep;
  logic                accept;
  logic [6:0]          cnt_q;
  logic [2*XLEN-1:0]   rq_q;         // remainder : quotient
  logic [XLEN-1:0]     divisor_q;
  logic                q_neg_q;
  logic                r_neg_q;
  logic                word_q;
  logic                rem_q;
  logic                special_q;
  logic [XLEN-1:0]     special_res_q;
  logic [TAG_W-1:0]    tag_q;
  logic [XLEN:0]       diff;
  logic [XLEN-1:0]     q_fix;
  logic [XLEN-1:0]     r_fix;
  logic [XLEN-1:0]     sel;

  div_operand_prep u_prep (
    .req_i  (req_i),
    .prep_o (prep)
  );

  assign accept = (state_q == DIV_IDLE) & req_valid_i & is_div_op(req_i.op);
  assign diff   = rq_q[2*XLEN-1:XLEN-1] - {1'b0, divisor_q};   // trial subtract

  // ==========================================================
  // fsm
  // ==========================================================
  always_ff @(posedge clk) begin
    if (rst_n) begin
      state_q <= DIV_IDLE;
      cnt_q   <= '0;
    end else begin
      case (state_q)
        DIV_IDLE: begin
          if (accept) begin
            state_q <= prep.special ? DIV_DONE : DIV_RUN;
            cnt_q   <= prep.word ? 7'd32 : 7'd64;
          end
        end
        DIV_RUN: begin
          if (cnt_q == '0) begin
            state_q <= DIV_DONE;
          end else begin
            cnt_q <= cnt_q - 7'd1;
          end
        end
        DIV_DONE: begin
          if (grant_i) state_q <= DIV_IDLE;                  // held until arbiter takes it
        end
        default: state_q <= DIV_IDLE;
      endcase
    end
  end

  // ==========================================================
  // datapath
  // ==========================================================
  always_ff @(posedge clk) begin
    if (accept) begin
      rq_q          <= {{XLEN{1'b0}}, prep.dividend};
      divisor_q     <= prep.divisor;
      q_neg_q       <= prep.q_neg;
      r_neg_q       <= prep.r_neg;
      word_q        <= prep.word;
      special_q     <= prep.special;
      special_res_q <= prep.special_res;
      rem_q         <= is_rem_op(req_i.op);
      tag_q         <= req_i.tag;
    end else if (state_q == DIV_RUN && cnt_q != '0) begin
      if (diff[XLEN]) begin
        rq_q <= {rq_q[2*XLEN-2:0], 1'b0};                    // borrow, keep remainder
      end else begin
        rq_q <= {diff[XLEN-1:0], rq_q[XLEN-2:0], 1'b1};
      end
    end
  end

  // sign fix-up on the way out
  assign q_fix = q_neg_q ? -rq_q[XLEN-1:0] : rq_q[XLEN-1:0];
  assign r_fix = r_neg_q ? -rq_q[2*XLEN-1:XLEN] : rq_q[2*XLEN-1:XLEN];
  assign sel   = rem_q ? r_fix : q_fix;

  assign busy_o = (state_q != DIV_IDLE);
  assign done_o = (state_q == DIV_DONE);
  assign rsp_o  = '{value: special_q ? special_res_q : (word_q ? sext32(sel[31:0]) : sel),
                    tag:   tag_q};

endmodule

`default_nettype wire

// File: hw/div_operand_prep.sv
`default_nettype none

module div_operand_prep (
  input  wire mdu_pkg::mdu_req_t  req_i,
  output mdu_pkg::div_prep_t      prep_o
);
  import mdu_pkg::*;

  logic            is_signed;
  logic            is_word;
  logic            is_rem;
  logic [XLEN-1:0] a_ext;
  logic [XLEN-1:0] b_ext;
  logic [XLEN-1:0] a_sx;
  logic            a_neg;
  logic            b_neg;
  logic [XLEN-1:0] a_mag;
  logic [XLEN-1:0] b_mag;
  logic [XLEN-1:0] min_neg;
  logic            div_zero;
  logic            overflow;

  assign is_signed = req_i.op inside {OP_DIV, OP_REM, OP_DIVW, OP_REMW};
  assign is_word   = req_i.op inside {OP_DIVW, OP_DIVUW, OP_REMW, OP_REMUW};
  assign is_rem    = is_rem_op(req_i.op);

  // ==========================================================
  // operand extension and magnitudes
  // ==========================================================
  assign a_sx  = is_word ? sext32(req_i.a[31:0]) : req_i.a;    // raw dividend as seen by isa
  assign a_ext = (is_word && !is_signed) ? {32'b0, req_i.a[31:0]} : a_sx;
  assign b_ext = !is_word ? req_i.b :
                 is_signed ? sext32(req_i.b[31:0]) : {32'b0, req_i.b[31:0]};

  assign a_neg = is_signed & a_ext[XLEN-1];
  assign b_neg = is_signed & b_ext[XLEN-1];
  assign a_mag = a_neg ? -a_ext : a_ext;
  assign b_mag = b_neg ? -b_ext : b_ext;

  // ==========================================================
  // special cases
  // ==========================================================
  assign min_neg  = is_word ? sext32(32'h8000_0000) : {1'b1, {(XLEN-1){1'b0}}};
  assign div_zero = (b_ext == '0);
  assign overflow = is_signed & (a_ext == min_neg) & (&b_ext);   // most negative / -1

  always_comb begin
    prep_o.dividend = is_word ? {a_mag[31:0], 32'b0} : a_mag;  // 32 steps for word ops
    prep_o.divisor  = b_mag;
    prep_o.q_neg    = a_neg ^ b_neg;
    prep_o.r_neg    = a_neg;                                   // remainder follows dividend
    prep_o.word     = is_word;
    prep_o.special  = div_zero | overflow;
    if (div_zero) begin
      prep_o.special_res = is_rem ? a_sx : '1;
    end else begin
      prep_o.special_res = is_rem ? '0 : a_sx;
    end
  end

endmodule

`default_nettype wire

// File: hw/mdu_pkg.sv
`default_nettype none

package mdu_pkg;

  localparam int XLEN  = 64;
  localparam int TAG_W = 4;

  typedef enum logic [3:0] {
    OP_MUL,
    OP_MULH,
    OP_MULHSU,
    OP_MULHU,
    OP_MULW,
    OP_DIV,
    OP_DIVU,
    OP_REM,
    OP_REMU,
    OP_DIVW,
    OP_DIVUW,
    OP_REMW,
    OP_REMUW
  } mdu_op_e;

  typedef struct packed {
    mdu_op_e           op;
    logic [XLEN-1:0]   a;
    logic [XLEN-1:0]   b;
    logic [TAG_W-1:0]  tag;
  } mdu_req_t;

  typedef struct packed {
    logic [XLEN-1:0]   value;
    logic [TAG_W-1:0]  tag;
  } mdu_rsp_t;

  typedef struct packed {
    logic [XLEN-1:0]   dividend;     // magnitude, word forms in upper half
    logic [XLEN-1:0]   divisor;      // magnitude
    logic              q_neg;
    logic              r_neg;
    logic              word;
    logic              special;      // zero divisor or overflow
    logic [XLEN-1:0]   special_res;
  } div_prep_t;

  typedef enum logic [1:0] {DIV_IDLE, DIV_RUN, DIV_DONE} div_state_e;
  typedef enum logic [1:0] {MUL_IDLE, MUL_RUN, MUL_DONE} mul_state_e;

  function automatic logic is_div_op(mdu_op_e op);
    return op inside {OP_DIV, OP_DIVU, OP_REM, OP_REMU,
                      OP_DIVW, OP_DIVUW, OP_REMW, OP_REMUW};
  endfunction

  function automatic logic is_mul_op(mdu_op_e op);
    return op inside {OP_MUL, OP_MULH, OP_MULHSU, OP_MULHU, OP_MULW};
  endfunction

  function automatic logic is_rem_op(mdu_op_e op);
    return op inside {OP_REM, OP_REMU, OP_REMW, OP_REMUW};
  endfunction

  function automatic logic [XLEN-1:0] sext32(logic [31:0] v);
    return {{(XLEN-32){v[31]}}, v};
  endfunction

endpackage

`default_nettype wire
